/* src.f */
source/dmem_pkg.sv
source/cache_pkg.sv
source/cache_port_if.sv
source/dmem_req_decode.sv
source/dmem_cache_bridge.sv
source/dmem_rdata_return.sv
source/dcache.sv
source/backing_mem.sv
source/io_bram.sv
source/dmem_subsys_top.sv
bench/dmem_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module dmem_subsys_tb \
  -o dmem_sim || { echo "Build of the simulation did not succeed"; exit 1; }
out=$(./obj_dir/dmem_sim)
echo "$out"
echo "$out" | grep -qx "Simulation passed" && echo "PASS" || { echo "FAIL"; exit 1; }

/* bench/dmem_subsys_tb.sv */
`timescale 1ns/1ps

module dmem_subsys_tb
  import dmem_pkg::*;
  import cache_pkg::*;
();

  localparam int STALL_LIMIT = 40;
  localparam int B2B_LOADS   = 16;

  typedef struct {
    int                test;
    logic              is_store;
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   data;
    logic [STRB_W-1:0] strb;
    logic              must_stall;
    logic              has_exp;
    logic [XLEN-1:0]   exp;
  } entry_t;

  logic              clk;
  logic              rst_n;
  logic              dmem_ren;
  logic [XLEN-1:0]   dmem_raddr;
  logic              dmem_we;
  logic [XLEN-1:0]   dmem_waddr;
  logic [XLEN-1:0]   dmem_wdata;
  logic [STRB_W-1:0] dmem_wstrb;
  logic [XLEN-1:0]   dmem_rdata;
  logic              dmem_stall;

  entry_t            table_q [$];
  logic [XLEN-1:0]   cache_model [MEM_WORDS];
  logic [XLEN-1:0]   io_model [IO_WORDS];
  logic [31:0]       lfsr;
  string             test_name [6];
  int                test_errors;
  int                tests_passed;
  int                tests_failed;

  dmem_subsys_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_rdata (dmem_rdata),
    .dmem_stall (dmem_stall)
  );

  always #2 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [XLEN-1:0] model_word(input logic [XLEN-1:0] addr);
    if (addr[IO_SEL_BIT]) begin
      return io_model[addr[BYTE_OFF_W +: IO_AW]];
    end else begin
      return cache_model[addr[BYTE_OFF_W +: MEM_AW]];
    end
  endfunction

  function automatic void write_model(input logic [XLEN-1:0] addr,
                                      input logic [XLEN-1:0] data,
                                      input logic [STRB_W-1:0] strb);
    logic [XLEN-1:0] word;
    word = model_word(addr);
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    if (addr[IO_SEL_BIT]) begin
      io_model[addr[BYTE_OFF_W +: IO_AW]] = word;
    end else begin
      cache_model[addr[BYTE_OFF_W +: MEM_AW]] = word;
    end
  endfunction

  function automatic void add_load(input int test, input logic [XLEN-1:0] addr,
                                   input logic must_stall, input logic has_exp,
                                   input logic [XLEN-1:0] exp);
    entry_t e;
    e = '{test, 1'b0, addr, '0, '0, must_stall, has_exp, exp};
    table_q.push_back(e);
  endfunction

  function automatic void add_store(input int test, input logic [XLEN-1:0] addr,
                                    input logic [XLEN-1:0] data,
                                    input logic [STRB_W-1:0] strb, input logic must_stall);
    entry_t e;
    e = '{test, 1'b1, addr, data, strb, must_stall, 1'b0, '0};
    table_q.push_back(e);
  endfunction

  function automatic void build_table();
    // Cold miss then hit, memory starts at zero
    add_load(1, 32'h0000_0104, 1'b1, 1'b1, 32'h0000_0000);
    add_load(1, 32'h0000_0104, 1'b0, 1'b1, 32'h0000_0000);
    // Resident line merges, non-resident line is fetched later
    add_store(2, 32'h0000_0104, 32'h1122_3344, 4'b0011, 1'b1);
    add_load(2, 32'h0000_0104, 1'b0, 1'b1, 32'h0000_3344);
    add_store(2, 32'h0000_0208, rand_bits(32), 4'b1100, 1'b1);
    add_load(2, 32'h0000_0208, 1'b1, 1'b0, '0);
    add_load(2, 32'h0000_0208, 1'b0, 1'b0, '0);
    // Same index 3, tags 0 and 1
    add_store(3, 32'h0000_000c, rand_bits(32), 4'b1111, 1'b1);
    add_store(3, 32'h0000_004c, rand_bits(32), 4'b1111, 1'b1);
    add_load(3, 32'h0000_000c, 1'b1, 1'b0, '0);
    add_load(3, 32'h0000_004c, 1'b1, 1'b0, '0);
    add_load(3, 32'h0000_000c, 1'b1, 1'b0, '0);
    add_load(3, 32'h0000_000c, 1'b0, 1'b0, '0);
    // I/O word and a cached word with the same low bits
    add_store(4, 32'h8000_0010, rand_bits(32), 4'b1111, 1'b0);
    add_store(4, 32'h8000_0010, 32'ha5a5_a5a5, 4'b0100, 1'b0);
    add_load(4, 32'h8000_0010, 1'b0, 1'b0, '0);
    add_load(4, 32'h0000_0010, 1'b1, 1'b1, 32'h0000_0000);
    add_store(4, 32'h0000_0010, rand_bits(32), 4'b1111, 1'b1);
    add_load(4, 32'h8000_0010, 1'b0, 1'b0, '0);
    add_load(4, 32'h0000_0010, 1'b0, 1'b0, '0);
  endfunction

  task automatic abort_run(input logic [XLEN-1:0] addr);
    $display("Timeout: dmem_stall stayed high for %0d cycles after the access to 0x%08h",
             STALL_LIMIT, addr);
    $display("Simulation failed");
    $finish;
  endtask

  // One access, then wait until the CPU is released
  task automatic run_entry(input entry_t e);
    logic stalled;
    int   cycles;
    @(posedge clk);
    if (e.is_store) begin
      dmem_we    <= 1'b1;
      dmem_waddr <= e.addr;
      dmem_wdata <= e.data;
      dmem_wstrb <= e.strb;
    end else begin
      dmem_ren   <= 1'b1;
      dmem_raddr <= e.addr;
    end
    @(posedge clk);
    dmem_we  <= 1'b0;
    dmem_ren <= 1'b0;
    @(negedge clk);
    stalled = dmem_stall;
    cycles  = 0;
    while (dmem_stall && cycles < STALL_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (dmem_stall) begin
      abort_run(e.addr);
    end else begin
      if (stalled !== e.must_stall) begin
        $display("Error at %0t: access to 0x%08h stall was %0b, expected %0b",
                 $time, e.addr, stalled, e.must_stall);
        test_errors++;
      end
      if (e.is_store) begin
        write_model(e.addr, e.data, e.strb);
      end else begin
        if (dmem_rdata !== model_word(e.addr)) begin
          $display("Error at %0t: load 0x%08h returned 0x%08h, expected 0x%08h",
                   $time, e.addr, dmem_rdata, model_word(e.addr));
          test_errors++;
        end
        if (e.has_exp && dmem_rdata !== e.exp) begin
          $display("Error at %0t: load 0x%08h returned 0x%08h, fixed value 0x%08h",
                   $time, e.addr, dmem_rdata, e.exp);
          test_errors++;
        end
      end
    end
  endtask

  task automatic back_to_back_hits();
    entry_t          e;
    logic [XLEN-1:0] pick;
    logic [XLEN-1:0] addrs [B2B_LOADS];
    // Warm up lines 8 to 11
    for (int k = 0; k < 4; k++) begin
      e = '{5, 1'b1, 32'h0000_0020 + 32'(4 * k), rand_bits(32), 4'hf, 1'b1, 1'b0, '0};
      run_entry(e);
      e.is_store = 1'b0;
      run_entry(e);
    end
    for (int i = 0; i < B2B_LOADS; i++) begin
      pick = rand_bits(2);
      addrs[i] = 32'h0000_0020 + {pick[XLEN-3:0], 2'b00};
    end
    // Data of load i-1 is checked in the cycle load i is issued
    for (int i = 0; i < B2B_LOADS; i++) begin
      @(posedge clk);
      dmem_ren   <= 1'b1;
      dmem_raddr <= addrs[i];
      @(negedge clk);
      if (dmem_stall !== 1'b0) begin
        $display("Error at %0t: back-to-back load %0d stalled", $time, i);
        test_errors++;
      end
      if (i > 0 && dmem_rdata !== model_word(addrs[i-1])) begin
        $display("Error at %0t: hit load 0x%08h returned 0x%08h, expected 0x%08h",
                 $time, addrs[i-1], dmem_rdata, model_word(addrs[i-1]));
        test_errors++;
      end
    end
    @(posedge clk);
    dmem_ren <= 1'b0;
    @(negedge clk);
    if (dmem_stall !== 1'b0 || dmem_rdata !== model_word(addrs[B2B_LOADS-1])) begin
      $display("Error at %0t: last hit load 0x%08h returned 0x%08h, expected 0x%08h",
               $time, addrs[B2B_LOADS-1], dmem_rdata, model_word(addrs[B2B_LOADS-1]));
      test_errors++;
    end
  endtask

  task automatic finish_test(input int id);
    if (test_errors == 0) begin
      $display("Test %0d (%s) ok", id, test_name[id]);
      tests_passed++;
    end else begin
      $display("Test %0d (%s) FAILED with %0d errors", id, test_name[id], test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  initial begin
    int cur;
    clk        = 1'b0;
    rst_n      = 1'b0;
    dmem_ren   = 1'b0;
    dmem_raddr = '0;
    dmem_we    = 1'b0;
    dmem_waddr = '0;
    dmem_wdata = '0;
    dmem_wstrb = '0;
    lfsr         = 32'hf140;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_name = '{"reset", "cold cache load", "cache store merge", "eviction",
                  "I/O bypass", "back-to-back hits"};
    foreach (cache_model[i]) begin
      cache_model[i] = '0;
    end
    foreach (io_model[i]) begin
      io_model[i] = '0;
    end
    build_table();

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (dmem_stall !== 1'b0) begin
      $display("Error at %0t: dmem_stall is %b after reset", $time, dmem_stall);
      test_errors++;
    end
    finish_test(0);

    cur = table_q[0].test;
    foreach (table_q[i]) begin
      if (table_q[i].test != cur) begin
        finish_test(cur);
        cur = table_q[i].test;
      end
      run_entry(table_q[i]);
    end
    finish_test(cur);

    back_to_back_hits();
    finish_test(5);

    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* source/dmem_subsys_top.sv */
`timescale 1ns/1ps

module dmem_subsys_top
  import dmem_pkg::*;
  import cache_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              dmem_ren,
  input  logic [XLEN-1:0]   dmem_raddr,
  input  logic              dmem_we,
  input  logic [XLEN-1:0]   dmem_waddr,
  input  logic [XLEN-1:0]   dmem_wdata,
  input  logic [STRB_W-1:0] dmem_wstrb,
  output logic [XLEN-1:0]   dmem_rdata,
  output logic              dmem_stall
);

  logic                 cache_load;
  logic                 cache_store;
  logic                 io_load;
  logic                 io_ren;
  logic                 io_wen;
  logic [XLEN-1:0]      io_raddr;
  logic [XLEN-1:0]      io_waddr;
  logic [XLEN-1:0]      io_wdata;
  logic [STRB_W-1:0]    io_wstrb;
  logic [XLEN-1:0]      io_rdata;
  logic                 miss_return;
  logic                 wait_hit;
  logic                 mem_req;
  logic                 mem_we;
  logic [MEM_AW-1:0]    mem_addr;
  logic [LINE_W-1:0]    mem_wdata;
  logic [LINE_STRB-1:0] mem_wstrb;
  logic                 mem_done;
  logic [LINE_W-1:0]    mem_rdata;

  cache_port_if cport ();

  dmem_req_decode u_decode (
    .dmem_ren    (dmem_ren),
    .dmem_we     (dmem_we),
    .dmem_raddr  (dmem_raddr),
    .dmem_waddr  (dmem_waddr),
    .dmem_wdata  (dmem_wdata),
    .dmem_wstrb  (dmem_wstrb),
    .cache_load  (cache_load),
    .cache_store (cache_store),
    .io_load     (io_load),
    .io_ren      (io_ren),
    .io_wen      (io_wen),
    .io_raddr    (io_raddr),
    .io_waddr    (io_waddr),
    .io_wdata    (io_wdata),
    .io_wstrb    (io_wstrb)
  );

  dmem_cache_bridge u_bridge (
    .clk         (clk),
    .rst_n       (rst_n),
    .cache_load  (cache_load),
    .cache_store (cache_store),
    .dmem_raddr  (dmem_raddr),
    .dmem_waddr  (dmem_waddr),
    .dmem_wdata  (dmem_wdata),
    .dmem_wstrb  (dmem_wstrb),
    .dmem_stall  (dmem_stall),
    .miss_return (miss_return),
    .wait_hit    (wait_hit),
    .cport       (cport.bridge)
  );

  dmem_rdata_return u_return (
    .clk           (clk),
    .rst_n         (rst_n),
    .io_load       (io_load),
    .dmem_stall    (dmem_stall),
    .miss_return   (miss_return),
    .wait_hit      (wait_hit),
    .rd_data_valid (cport.rd_data_valid),
    .rd_data       (cport.rd_data),
    .io_rdata      (io_rdata),
    .dmem_rdata    (dmem_rdata)
  );

  dcache u_dcache (
    .clk       (clk),
    .rst_n     (rst_n),
    .cport     (cport.cache),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_done  (mem_done),
    .mem_rdata (mem_rdata)
  );

  backing_mem u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_done  (mem_done),
    .mem_rdata (mem_rdata)
  );

  io_bram u_io (
    .clk      (clk),
    .io_ren   (io_ren),
    .io_wen   (io_wen),
    .io_raddr (io_raddr),
    .io_waddr (io_waddr),
    .io_wdata (io_wdata),
    .io_wstrb (io_wstrb),
    .io_rdata (io_rdata)
  );

endmodule

/* source/io_bram.sv */
`timescale 1ns/1ps

module io_bram
  import dmem_pkg::*;
(
  input  logic              clk,
  input  logic              io_ren,
  input  logic              io_wen,
  input  logic [XLEN-1:0]   io_raddr,
  input  logic [XLEN-1:0]   io_waddr,
  input  logic [XLEN-1:0]   io_wdata,
  input  logic [STRB_W-1:0] io_wstrb,
  output logic [XLEN-1:0]   io_rdata
);

  logic [XLEN-1:0] ram [IO_WORDS];

  initial begin
    for (int i = 0; i < IO_WORDS; i++) begin
      ram[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (io_wen) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (io_wstrb[b]) begin
          ram[io_waddr[BYTE_OFF_W +: IO_AW]][8*b +: 8] <= io_wdata[8*b +: 8];
        end
      end
    end
    // Registered read
    if (io_ren) begin
      io_rdata <= ram[io_raddr[BYTE_OFF_W +: IO_AW]];
    end
  end

endmodule

/* source/backing_mem.sv */
`timescale 1ns/1ps

module backing_mem
  import cache_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 mem_req,
  input  logic                 mem_we,
  input  logic [MEM_AW-1:0]    mem_addr,
  input  logic [LINE_W-1:0]    mem_wdata,
  input  logic [LINE_STRB-1:0] mem_wstrb,
  output logic                 mem_done,
  output logic [LINE_W-1:0]    mem_rdata
);

  logic [LINE_W-1:0]    mem [MEM_WORDS];
  logic [LAT_W-1:0]     lat_cnt;
  logic                 req_we;
  logic [MEM_AW-1:0]    req_addr;
  logic [LINE_W-1:0]    req_wdata;
  logic [LINE_STRB-1:0] req_wstrb;

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // Counter loads on the request, done fires MEM_LATENCY cycles later
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lat_cnt  <= '0;
      mem_done <= 1'b0;
    end else begin
      mem_done <= (lat_cnt == LAT_W'(1));
      if (mem_req) begin
        lat_cnt <= LAT_W'(MEM_LATENCY - 1);
      end else if (lat_cnt != '0) begin
        lat_cnt <= lat_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req) begin
      req_we    <= mem_we;
      req_addr  <= mem_addr;
      req_wdata <= mem_wdata;
      req_wstrb <= mem_wstrb;
    end
    if (lat_cnt == LAT_W'(1)) begin
      mem_rdata <= mem[req_addr];
      for (int b = 0; b < LINE_STRB; b++) begin
        if (req_we && req_wstrb[b]) begin
          mem[req_addr][8*b +: 8] <= req_wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

/* source/dcache.sv */
`timescale 1ns/1ps

module dcache
  import cache_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  cache_port_if.cache          cport,
  output logic                 mem_req,
  output logic                 mem_we,
  output logic [MEM_AW-1:0]    mem_addr,
  output logic [LINE_W-1:0]    mem_wdata,
  output logic [LINE_STRB-1:0] mem_wstrb,
  input  logic                 mem_done,
  input  logic [LINE_W-1:0]    mem_rdata
);

  typedef enum logic [1:0] {
    C_IDLE,
    C_FILL,
    C_WRITE
  } cstate_t;

  cstate_t            state;
  logic [TAG_W-1:0]   tag_q [LINES];
  logic [LINE_W-1:0]  data_q [LINES];
  logic [LINES-1:0]   valid_q;
  logic [INDEX_W-1:0] rd_idx;
  logic [INDEX_W-1:0] wr_idx;
  logic [INDEX_W-1:0] fill_idx;
  logic [TAG_W-1:0]   rd_tag;
  logic [TAG_W-1:0]   wr_tag;
  logic [TAG_W-1:0]   fill_tag;
  logic               rd_accept;
  logic               wr_accept;
  logic               wr_hit;
  logic [LINE_W-1:0]  rd_data_q;
  logic               rd_data_valid_q;
  logic               wr_ready_q;
  logic               mem_busy;

  assign rd_idx = cport.rd_addr[OFFSET_W +: INDEX_W];
  assign rd_tag = cport.rd_addr[OFFSET_W + INDEX_W +: TAG_W];
  assign wr_idx = cport.wr_addr[OFFSET_W +: INDEX_W];
  assign wr_tag = cport.wr_addr[OFFSET_W + INDEX_W +: TAG_W];

  // Combinational lookup
  assign cport.rd_ready = (state == C_IDLE);
  assign cport.rd_hit   = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign wr_hit         = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

  assign rd_accept = cport.rd_valid && (state == C_IDLE);
  // The store stays valid in its wr_ready cycle and must not start twice
  assign wr_accept = cport.wr_valid && (state == C_IDLE) && !wr_ready_q;

  // Memory sees the request in the cycle it is accepted
  assign mem_req   = wr_accept || (rd_accept && !cport.rd_hit);
  assign mem_we    = wr_accept;
  assign mem_addr  = wr_accept ? cport.wr_addr[OFFSET_W +: MEM_AW]
                               : cport.rd_addr[OFFSET_W +: MEM_AW];
  assign mem_wdata = cport.wr_data;
  assign mem_wstrb = cport.wr_strb;

  assign cport.rd_data       = rd_data_q;
  assign cport.rd_data_valid = rd_data_valid_q;
  assign cport.wr_ready      = wr_ready_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state           <= C_IDLE;
      valid_q         <= '0;
      rd_data_valid_q <= 1'b0;
      wr_ready_q      <= 1'b0;
      mem_busy        <= 1'b0;
    end else begin
      rd_data_valid_q <= 1'b0;
      wr_ready_q      <= 1'b0;
      if (mem_req) begin
        mem_busy <= 1'b1;
      end else if (mem_done) begin
        mem_busy <= 1'b0;
      end
      unique case (state)
        C_IDLE: begin
          if (wr_accept) begin
            state <= C_WRITE;
          end else if (rd_accept) begin
            if (cport.rd_hit) begin
              rd_data_valid_q <= 1'b1;
            end else begin
              state <= C_FILL;
            end
          end
        end
        C_FILL: begin
          if (mem_done) begin
            state             <= C_IDLE;
            valid_q[fill_idx] <= 1'b1;
            rd_data_valid_q   <= 1'b1;
          end
        end
        C_WRITE: begin
          if (mem_done) begin
            state      <= C_IDLE;
            wr_ready_q <= 1'b1;
          end
        end
        default: begin
          state <= C_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rd_data_q <= data_q[rd_idx];
      fill_idx  <= rd_idx;
      fill_tag  <= rd_tag;
    end
    if ((state == C_FILL) && mem_done) begin
      data_q[fill_idx] <= mem_rdata;
      tag_q[fill_idx]  <= fill_tag;
      rd_data_q        <= mem_rdata;
    end
    // Write-through with no allocation, a resident line merges the bytes
    if (wr_accept && wr_hit) begin
      for (int b = 0; b < LINE_STRB; b++) begin
        if (cport.wr_strb[b]) begin
          data_q[wr_idx][8*b +: 8] <= cport.wr_data[8*b +: 8];
        end
      end
    end
  end

  a_one_mem_op: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req |-> !mem_busy);

endmodule

/* source/dmem_rdata_return.sv */
`timescale 1ns/1ps

module dmem_rdata_return
  import dmem_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            io_load,
  input  logic            dmem_stall,
  input  logic            miss_return,
  input  logic            wait_hit,
  input  logic            rd_data_valid,
  input  logic [XLEN-1:0] rd_data,
  input  logic [XLEN-1:0] io_rdata,
  output logic [XLEN-1:0] dmem_rdata
);

  logic [XLEN-1:0] hold_data;
  logic            hold_valid;
  logic            io_sel_p1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hold_valid <= 1'b0;
      io_sel_p1  <= 1'b0;
    end else begin
      hold_valid <= miss_return || wait_hit;
      // I/O RAM answers one cycle after an unstalled request
      if (!dmem_stall) begin
        io_sel_p1 <= io_load;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_data_valid) begin
      hold_data <= rd_data;
    end
  end

  // Live cache data wins, then held miss data, then I/O
  always_comb begin
    if (rd_data_valid) begin
      dmem_rdata = rd_data;
    end else if ((dmem_stall || hold_valid) && !io_sel_p1) begin
      dmem_rdata = hold_data;
    end else if (io_sel_p1) begin
      dmem_rdata = io_rdata;
    end else begin
      dmem_rdata = '0;
    end
  end

  // Cache data keeps reaching the CPU in the held cycle after it returned
  a_held_data: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rd_data_valid) && !rd_data_valid && (dmem_stall || hold_valid)
      |-> dmem_rdata == $past(rd_data));

endmodule

/* source/dmem_cache_bridge.sv */
`timescale 1ns/1ps

module dmem_cache_bridge
  import dmem_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cache_load,
  input  logic              cache_store,
  input  logic [XLEN-1:0]   dmem_raddr,
  input  logic [XLEN-1:0]   dmem_waddr,
  input  logic [XLEN-1:0]   dmem_wdata,
  input  logic [STRB_W-1:0] dmem_wstrb,
  output logic              dmem_stall,
  output logic              miss_return,
  output logic              wait_hit,
  cache_port_if.bridge      cport
);

  typedef enum logic [2:0] {
    STATE_IDLE,
    STATE_WAIT_CACHE,
    STATE_MISS,
    STATE_MISS_RETURN,
    STATE_STORE
  } state_t;

  state_t            state;
  state_t            state_next;
  logic              rd_start;
  logic              wr_start;
  logic [XLEN-1:0]   rd_addr_q;
  logic [XLEN-1:0]   wr_addr_q;
  logic [XLEN-1:0]   wr_data_q;
  logic [STRB_W-1:0] wr_strb_q;

  // New requests start only from IDLE, straight from the live inputs
  assign rd_start = (state == STATE_IDLE) && cache_load;
  assign wr_start = (state == STATE_IDLE) && cache_store;

  assign cport.rd_valid = rd_start || (state == STATE_WAIT_CACHE);
  assign cport.rd_addr  = rd_start ? dmem_raddr : rd_addr_q;

  assign cport.wr_valid = wr_start || (state == STATE_STORE);
  assign cport.wr_addr  = wr_start ? dmem_waddr : wr_addr_q;
  assign cport.wr_data  = wr_start ? dmem_wdata : wr_data_q;
  assign cport.wr_strb  = wr_start ? dmem_wstrb : wr_strb_q;

  assign dmem_stall  = (state != STATE_IDLE);
  assign miss_return = (state == STATE_MISS_RETURN);
  // A delayed hit returns while the CPU is already unstalled
  assign wait_hit    = (state == STATE_WAIT_CACHE) && cport.rd_ready && cport.rd_hit;

  always_comb begin
    state_next = state;
    unique case (state)
      STATE_IDLE: begin
        if (wr_start) begin
          state_next = STATE_STORE;
        end else if (rd_start) begin
          if (!cport.rd_ready) begin
            state_next = STATE_WAIT_CACHE;
          end else if (!cport.rd_hit) begin
            state_next = STATE_MISS;
          end
        end
      end
      STATE_WAIT_CACHE: begin
        if (cport.rd_ready) begin
          state_next = cport.rd_hit ? STATE_IDLE : STATE_MISS;
        end
      end
      STATE_MISS: begin
        if (cport.rd_data_valid) begin
          state_next = STATE_MISS_RETURN;
        end
      end
      STATE_MISS_RETURN: begin
        state_next = STATE_IDLE;
      end
      STATE_STORE: begin
        if (cport.wr_ready) begin
          state_next = STATE_IDLE;
        end
      end
      default: begin
        state_next = STATE_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= STATE_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Held copies for the retry and store cycles
  always_ff @(posedge clk) begin
    if (rd_start) begin
      rd_addr_q <= dmem_raddr;
    end
    if (wr_start) begin
      wr_addr_q <= dmem_waddr;
      wr_data_q <= dmem_wdata;
      wr_strb_q <= dmem_wstrb;
    end
  end

  a_cache_addr_not_io: assert property (@(posedge clk) disable iff (!rst_n)
    (cport.rd_valid |-> !cport.rd_addr[IO_SEL_BIT]) and
    (cport.wr_valid |-> !cport.wr_addr[IO_SEL_BIT]));

  a_rd_held: assert property (@(posedge clk) disable iff (!rst_n)
    cport.rd_valid && !cport.rd_ready |=> cport.rd_valid && $stable(cport.rd_addr));

  a_wr_held: assert property (@(posedge clk) disable iff (!rst_n)
    cport.wr_valid && !cport.wr_ready |=> cport.wr_valid && $stable(cport.wr_addr)
      && $stable(cport.wr_data) && $stable(cport.wr_strb));

  // The CPU stays held until the write-through has reached memory
  a_store_stalls: assert property (@(posedge clk) disable iff (!rst_n)
    cport.wr_ready |-> dmem_stall);

endmodule

/* source/dmem_req_decode.sv */
`timescale 1ns/1ps

module dmem_req_decode
  import dmem_pkg::*;
(
  input  logic              dmem_ren,
  input  logic              dmem_we,
  input  logic [XLEN-1:0]   dmem_raddr,
  input  logic [XLEN-1:0]   dmem_waddr,
  input  logic [XLEN-1:0]   dmem_wdata,
  input  logic [STRB_W-1:0] dmem_wstrb,
  output logic              cache_load,
  output logic              cache_store,
  output logic              io_load,
  output logic              io_ren,
  output logic              io_wen,
  output logic [XLEN-1:0]   io_raddr,
  output logic [XLEN-1:0]   io_waddr,
  output logic [XLEN-1:0]   io_wdata,
  output logic [STRB_W-1:0] io_wstrb
);

  // Split by the I/O select bit
  assign cache_load  = dmem_ren && !dmem_raddr[IO_SEL_BIT];
  assign cache_store = dmem_we && !dmem_waddr[IO_SEL_BIT];
  assign io_load     = dmem_ren && dmem_raddr[IO_SEL_BIT];

  // I/O accesses go straight to the RAM
  assign io_ren   = io_load;
  assign io_wen   = dmem_we && dmem_waddr[IO_SEL_BIT];
  assign io_raddr = dmem_raddr;
  assign io_waddr = dmem_waddr;
  assign io_wdata = dmem_wdata;
  assign io_wstrb = dmem_wstrb;

  // The CPU issues a load or a store, never both
  always_comb begin
    assert (!(dmem_ren && dmem_we))
      else $error("dmem_ren and dmem_we asserted together");
  end

endmodule

/* source/cache_port_if.sv */
`timescale 1ns/1ps

interface cache_port_if
  import dmem_pkg::*;
();

  // Read channel
  logic              rd_valid;
  logic [XLEN-1:0]   rd_addr;
  logic              rd_ready;
  logic              rd_hit;
  logic [XLEN-1:0]   rd_data;
  logic              rd_data_valid;

  // Write channel
  // wr_ready pulses once the write-through has reached memory
  logic              wr_valid;
  logic [XLEN-1:0]   wr_addr;
  logic [XLEN-1:0]   wr_data;
  logic [STRB_W-1:0] wr_strb;
  logic              wr_ready;

  modport bridge (
    output rd_valid, rd_addr,
    input  rd_ready, rd_hit, rd_data_valid,
    output wr_valid, wr_addr, wr_data, wr_strb,
    input  wr_ready
  );

  modport cache (
    input  rd_valid, rd_addr,
    output rd_ready, rd_hit, rd_data, rd_data_valid,
    input  wr_valid, wr_addr, wr_data, wr_strb,
    output wr_ready
  );

endinterface

/* source/cache_pkg.sv */
package cache_pkg;

  // One word per line, direct mapped
  localparam int LINES = 16;
  localparam int INDEX_W = $clog2(LINES);
  localparam int LINE_W = 32;
  localparam int LINE_STRB = LINE_W / 8;
  localparam int OFFSET_W = $clog2(LINE_STRB);

  // Bit 31 selects I/O, so the tag covers bits 30 down to 6
  localparam int TAG_W = 31 - INDEX_W - OFFSET_W;

  // Backing memory geometry and timing
  localparam int MEM_WORDS = 1024;
  localparam int MEM_AW = $clog2(MEM_WORDS);
  localparam int MEM_LATENCY = 4;
  localparam int LAT_W = $clog2(MEM_LATENCY);

endpackage

/* source/dmem_pkg.sv */
package dmem_pkg;

  // CPU data and address width
  localparam int XLEN = 32;

  // One strobe bit per byte lane
  localparam int STRB_W = XLEN / 8;
  localparam int BYTE_OFF_W = $clog2(STRB_W);

  // Address bit 31 set routes the access to the I/O RAM
  localparam int IO_SEL_BIT = 31;

  // I/O RAM depth in words
  localparam int IO_WORDS = 64;
  localparam int IO_AW = $clog2(IO_WORDS);

endpackage
